// ==== hw/dacfifo_pkg.sv ====
// fixed 2:1 dma to dac width ratio, 512 beat memory, register offsets are 4-bit byte addresses
`default_nettype none

package dacfifo_pkg;

  // ****************************
  // widths and sizes
  // ****************************
  localparam int dma_data_width = 64;
  localparam int dac_data_width = 32;
  localparam int dac_addr_width = 10;
  // one bit less on the write side, two samples per beat
  localparam int dma_addr_width = 9;

  // dma ready drops at this many beats in flight
  localparam int dma_thresh_hi = 507;

  // ****************************
  // register map
  // ****************************
  localparam int axil_addr_width = 4;
  localparam int axil_data_width = 32;

  localparam logic [axil_addr_width-1:0] reg_id_addr     = 4'h0;
  localparam logic [axil_addr_width-1:0] reg_ctrl_addr   = 4'h4;
  localparam logic [axil_addr_width-1:0] reg_status_addr = 4'h8;
  localparam logic [axil_addr_width-1:0] reg_level_addr  = 4'hC;

  // ascii "DACF"
  localparam logic [axil_data_width-1:0] dacfifo_id = 32'h4441_4346;

  localparam logic [1:0] resp_okay = 2'b00;

  // master side of the register bus
  typedef struct packed {
    logic [axil_addr_width-1:0]   aw_addr;
    logic                         aw_valid;
    logic [axil_data_width-1:0]   w_data;
    logic [axil_data_width/8-1:0] w_strb;
    logic                         w_valid;
    logic                         b_ready;
    logic [axil_addr_width-1:0]   ar_addr;
    logic                         ar_valid;
    logic                         r_ready;
  } axil_req_t;

  // slave side of the register bus
  typedef struct packed {
    logic                       aw_ready;
    logic                       w_ready;
    logic                       b_valid;
    logic [1:0]                 b_resp;
    logic                       ar_ready;
    logic                       r_valid;
    logic [axil_data_width-1:0] r_data;
    logic [1:0]                 r_resp;
  } axil_rsp_t;

endpackage

`default_nettype wire

// ==== hw/gray_ptr_sync.sv ====
// pointer must change by at most one per source clock for the gray code to cross safely
`default_nettype none

module gray_ptr_sync #(
  parameter int width = 9
) (
  input  logic             src_clk,
  input  logic             src_rst,
  input  logic             dst_clk,
  input  logic             dst_rst,
  input  logic [width-1:0] src_ptr,
  output logic [width-1:0] dst_ptr
);

  logic [width-1:0] src_gray;
  logic [width-1:0] sync_m1;
  logic [width-1:0] sync_m2;

  function automatic logic [width-1:0] bin2gray(input logic [width-1:0] b);
    return b ^ (b >> 1);
  endfunction

  function automatic logic [width-1:0] gray2bin(input logic [width-1:0] g);
    logic [width-1:0] b;
    b[width-1] = g[width-1];
    for (int i = width - 2; i >= 0; i--) begin
      b[i] = b[i+1] ^ g[i];
    end
    return b;
  endfunction

  // source side, gray code launched from a flop
  always_ff @(posedge src_clk) begin
    if (src_rst) begin
      src_gray <= '0;
    end else begin
      src_gray <= bin2gray(src_ptr);
    end
  end

  // two-stage synchronizer, then back to binary
  always_ff @(posedge dst_clk) begin
    if (dst_rst) begin
      sync_m1 <= '0;
      sync_m2 <= '0;
      dst_ptr <= '0;
    end else begin
      sync_m1 <= src_gray;
      sync_m2 <= sync_m1;
      dst_ptr <= gray2bin(sync_m2);
    end
  end

endmodule

`default_nettype wire

// ==== hw/dacfifo_mem_asym.sv ====
// no reset and no init, contents are undefined until written; read port lags one rd_clk
`default_nettype none

module dacfifo_mem_asym (
  input  logic                                   wr_clk,
  input  logic                                   wr_en,
  input  logic [dacfifo_pkg::dma_addr_width-1:0] wr_addr,
  input  logic [dacfifo_pkg::dma_data_width-1:0] wr_data,
  input  logic                                   rd_clk,
  input  logic [dacfifo_pkg::dac_addr_width-1:0] rd_addr,
  output logic [dacfifo_pkg::dac_data_width-1:0] rd_data
);

  import dacfifo_pkg::*;

  localparam int depth = 2 ** dma_addr_width;

  logic [dma_data_width-1:0] mem [depth];
  logic [dma_data_width-1:0] rd_word;

  // ****************************
  // 64-bit write port
  // ****************************
  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // ****************************
  // 32-bit read port
  // ****************************
  // upper address bits pick the word, bit 0 picks the half
  assign rd_word = mem[rd_addr[dac_addr_width-1:1]];

  always_ff @(posedge rd_clk) begin
    if (rd_addr[0]) begin
      rd_data <= rd_word[dma_data_width-1:dac_data_width];
    end else begin
      rd_data <= rd_word[dac_data_width-1:0];
    end
  end

endmodule

`default_nettype wire

// ==== hw/dacfifo_dma_wr.sv ====
// dac_rst must be held for at least two dma_clk edges; level sees the read side late, so it overestimates
`default_nettype none

module dacfifo_dma_wr (
  input  logic                                   dma_clk,
  input  logic                                   dac_rst,
  input  logic [dacfifo_pkg::dma_data_width-1:0] dma_data,
  input  logic                                   dma_valid,
  input  logic                                   xfer_en,
  input  logic [dacfifo_pkg::dac_addr_width-1:0] rd_ptr_sync,
  output logic                                   dma_rst,
  output logic                                   dma_ready,
  output logic                                   mem_wr_en,
  output logic [dacfifo_pkg::dma_addr_width-1:0] mem_wr_addr,
  output logic [dacfifo_pkg::dma_data_width-1:0] mem_wr_data,
  output logic [dacfifo_pkg::dma_addr_width-1:0] wr_ptr
);

  import dacfifo_pkg::*;

  logic                      rst_m1;
  logic                      xfer_m1;
  logic                      xfer_en_sync;
  logic [dma_addr_width-1:0] wr_addr;
  logic [dma_addr_width-1:0] level_s;
  logic [dma_addr_width-1:0] level_q;

  // ****************************
  // domain crossing
  // ****************************
  // reset comes over from the dac side
  always_ff @(posedge dma_clk) begin
    rst_m1  <= dac_rst;
    dma_rst <= rst_m1;
  end

  always_ff @(posedge dma_clk) begin
    if (dma_rst) begin
      xfer_m1      <= 1'b0;
      xfer_en_sync <= 1'b0;
    end else begin
      xfer_m1      <= xfer_en;
      xfer_en_sync <= xfer_m1;
    end
  end

  // ****************************
  // write pointer
  // ****************************
  // beats offered while disabled are dropped
  assign mem_wr_en   = dma_valid & dma_ready & xfer_en_sync;
  assign mem_wr_addr = wr_addr;
  assign mem_wr_data = dma_data;
  assign wr_ptr      = wr_addr;

  always_ff @(posedge dma_clk) begin
    if (dma_rst) begin
      wr_addr <= '0;
    end else if (mem_wr_en) begin
      wr_addr <= wr_addr + 1'b1;
    end
  end

  // beats in flight, read pointer counts samples so drop its bit 0
  assign level_s = wr_addr - rd_ptr_sync[dac_addr_width-1:1];

  always_ff @(posedge dma_clk) begin
    if (dma_rst) begin
      level_q   <= '0;
      dma_ready <= 1'b0;
    end else begin
      level_q   <= level_s;
      dma_ready <= (level_q < dma_thresh_hi);
    end
  end

endmodule

`default_nettype wire

// ==== hw/dacfifo_dac_rd.sv ====
// one sample per dac_valid cycle at most; dac_data holds the last sample until the next read lands
`default_nettype none

module dacfifo_dac_rd (
  input  logic                                   dac_clk,
  input  logic                                   dac_rst,
  input  logic                                   dac_valid,
  input  logic                                   xfer_en,
  input  logic [dacfifo_pkg::dma_addr_width-1:0] wr_ptr_sync,
  input  logic [dacfifo_pkg::dac_data_width-1:0] mem_rd_data,
  output logic [dacfifo_pkg::dac_addr_width-1:0] mem_rd_addr,
  output logic [dacfifo_pkg::dac_addr_width-1:0] rd_ptr,
  output logic [dacfifo_pkg::dac_data_width-1:0] dac_data,
  output logic                                   dac_dunf,
  output logic [dacfifo_pkg::dac_addr_width-1:0] level
);

  import dacfifo_pkg::*;

  logic [dac_addr_width-1:0] rd_addr;
  logic                      mem_ready;
  logic                      rd_accept;
  logic                      rd_pend;

  // ****************************
  // fill level in samples
  // ****************************
  // write pointer counts beats, two samples each
  assign level     = {wr_ptr_sync, 1'b0} - rd_addr;
  assign mem_ready = (level != '0);
  assign rd_accept = dac_valid & mem_ready;

  assign mem_rd_addr = rd_addr;
  assign rd_ptr      = rd_addr;

  always_ff @(posedge dac_clk) begin
    if (dac_rst) begin
      rd_addr <= '0;
      rd_pend <= 1'b0;
    end else begin
      rd_pend <= rd_accept;
      if (rd_accept) begin
        rd_addr <= rd_addr + 1'b1;
      end
    end
  end

  // ****************************
  // output and underflow
  // ****************************
  // memory read takes one cycle, this register adds the second
  always_ff @(posedge dac_clk) begin
    if (dac_rst) begin
      dac_data <= '0;
    end else if (rd_pend) begin
      dac_data <= mem_rd_data;
    end
  end

  // only sampled when the dac asks for data
  always_ff @(posedge dac_clk) begin
    if (dac_rst) begin
      dac_dunf <= 1'b0;
    end else if (dac_valid) begin
      dac_dunf <= xfer_en & ~mem_ready;
    end
  end

endmodule

`default_nettype wire

// ==== hw/dacfifo_csr.sv ====
// one outstanding write and one outstanding read; aw and w must be presented together
`default_nettype none

module dacfifo_csr (
  input  logic                                   dac_clk,
  input  logic                                   dac_rst,
  input  dacfifo_pkg::axil_req_t                 csr_req,
  input  logic                                   dac_dunf,
  input  logic [dacfifo_pkg::dac_addr_width-1:0] level,
  output dacfifo_pkg::axil_rsp_t                 csr_rsp,
  output logic                                   xfer_en
);

  import dacfifo_pkg::*;

  logic                       aw_ready_q;
  logic                       b_valid_q;
  logic                       ar_ready_q;
  logic                       r_valid_q;
  logic [axil_data_width-1:0] r_data_q;
  logic                       wr_go;
  logic                       wr_hs;
  logic                       rd_go;
  logic                       rd_hs;
  logic                       dunf_q;
  logic                       dunf_flag;
  logic                       dunf_clr;
  logic [axil_data_width-1:0] rd_mux;

  // ****************************
  // write channel
  // ****************************
  assign wr_go = csr_req.aw_valid & csr_req.w_valid & ~b_valid_q & ~aw_ready_q;
  assign wr_hs = aw_ready_q & csr_req.aw_valid & csr_req.w_valid;

  always_ff @(posedge dac_clk) begin
    if (dac_rst) begin
      aw_ready_q <= 1'b0;
      b_valid_q  <= 1'b0;
    end else begin
      // aw and w ready share one flop, single-cycle pulse
      aw_ready_q <= wr_go;
      if (wr_hs) begin
        b_valid_q <= 1'b1;
      end else if (csr_req.b_ready) begin
        b_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge dac_clk) begin
    if (dac_rst) begin
      xfer_en <= 1'b0;
    end else if (wr_hs && csr_req.aw_addr == reg_ctrl_addr && csr_req.w_strb[0]) begin
      xfer_en <= csr_req.w_data[0];
    end
  end

  // sticky underflow, set on the rising edge of dac_dunf, write one to clear
  assign dunf_clr = wr_hs & (csr_req.aw_addr == reg_status_addr) &
                    csr_req.w_strb[0] & csr_req.w_data[0];

  always_ff @(posedge dac_clk) begin
    if (dac_rst) begin
      dunf_q    <= 1'b0;
      dunf_flag <= 1'b0;
    end else begin
      dunf_q <= dac_dunf;
      if (dac_dunf && !dunf_q) begin
        dunf_flag <= 1'b1;
      end else if (dunf_clr) begin
        dunf_flag <= 1'b0;
      end
    end
  end

  // ****************************
  // read channel
  // ****************************
  assign rd_go = csr_req.ar_valid & ~r_valid_q & ~ar_ready_q;
  assign rd_hs = ar_ready_q & csr_req.ar_valid;

  always_comb begin
    case (csr_req.ar_addr)
      reg_id_addr:     rd_mux = dacfifo_id;
      reg_ctrl_addr:   rd_mux = {{(axil_data_width-1){1'b0}}, xfer_en};
      reg_status_addr: rd_mux = {{(axil_data_width-1){1'b0}}, dunf_flag};
      reg_level_addr:  rd_mux = {{(axil_data_width-dac_addr_width){1'b0}}, level};
      default:         rd_mux = '0;
    endcase
  end

  always_ff @(posedge dac_clk) begin
    if (dac_rst) begin
      ar_ready_q <= 1'b0;
      r_valid_q  <= 1'b0;
    end else begin
      ar_ready_q <= rd_go;
      if (rd_hs) begin
        r_valid_q <= 1'b1;
      end else if (csr_req.r_ready) begin
        r_valid_q <= 1'b0;
      end
    end
  end

  // payload only, qualified by r_valid
  always_ff @(posedge dac_clk) begin
    if (rd_hs) begin
      r_data_q <= rd_mux;
    end
  end

  assign csr_rsp.aw_ready = aw_ready_q;
  assign csr_rsp.w_ready  = aw_ready_q;
  assign csr_rsp.b_valid  = b_valid_q;
  assign csr_rsp.b_resp   = resp_okay;
  assign csr_rsp.ar_ready = ar_ready_q;
  assign csr_rsp.r_valid  = r_valid_q;
  assign csr_rsp.r_data   = r_data_q;
  assign csr_rsp.r_resp   = resp_okay;

endmodule

`default_nettype wire

// ==== hw/dacfifo_top.sv ====
// dac_clk and dma_clk are unrelated; all resets come from dac_rst, held two dma_clk edges or more
`default_nettype none

module dacfifo_top (
  input  logic                                   dac_clk,
  input  logic                                   dac_rst,
  input  logic                                   dma_clk,
  input  logic [dacfifo_pkg::dma_data_width-1:0] dma_data,
  input  logic                                   dma_valid,
  output logic                                   dma_ready,
  input  logic                                   dac_valid,
  output logic [dacfifo_pkg::dac_data_width-1:0] dac_data,
  output logic                                   dac_dunf,
  input  dacfifo_pkg::axil_req_t                 csr_req,
  output dacfifo_pkg::axil_rsp_t                 csr_rsp
);

  import dacfifo_pkg::*;

  logic                      dma_rst;
  logic                      xfer_en;
  logic [dac_addr_width-1:0] level;
  logic                      mem_wr_en;
  logic [dma_addr_width-1:0] mem_wr_addr;
  logic [dma_data_width-1:0] mem_wr_data;
  logic [dac_addr_width-1:0] mem_rd_addr;
  logic [dac_data_width-1:0] mem_rd_data;
  logic [dma_addr_width-1:0] wr_ptr;
  logic [dma_addr_width-1:0] wr_ptr_sync;
  logic [dac_addr_width-1:0] rd_ptr;
  logic [dac_addr_width-1:0] rd_ptr_sync;

  dacfifo_csr i_csr (
    .dac_clk (dac_clk),
    .dac_rst (dac_rst),
    .csr_req (csr_req),
    .dac_dunf(dac_dunf),
    .level   (level),
    .csr_rsp (csr_rsp),
    .xfer_en (xfer_en)
  );

  // ****************************
  // dma_clk side
  // ****************************
  dacfifo_dma_wr i_dma_wr (
    .dma_clk    (dma_clk),
    .dac_rst    (dac_rst),
    .dma_data   (dma_data),
    .dma_valid  (dma_valid),
    .xfer_en    (xfer_en),
    .rd_ptr_sync(rd_ptr_sync),
    .dma_rst    (dma_rst),
    .dma_ready  (dma_ready),
    .mem_wr_en  (mem_wr_en),
    .mem_wr_addr(mem_wr_addr),
    .mem_wr_data(mem_wr_data),
    .wr_ptr     (wr_ptr)
  );

  gray_ptr_sync #(.width(dma_addr_width)) i_wr_ptr_sync (
    .src_clk(dma_clk),
    .src_rst(dma_rst),
    .dst_clk(dac_clk),
    .dst_rst(dac_rst),
    .src_ptr(wr_ptr),
    .dst_ptr(wr_ptr_sync)
  );

  dacfifo_mem_asym i_mem (
    .wr_clk (dma_clk),
    .wr_en  (mem_wr_en),
    .wr_addr(mem_wr_addr),
    .wr_data(mem_wr_data),
    .rd_clk (dac_clk),
    .rd_addr(mem_rd_addr),
    .rd_data(mem_rd_data)
  );

  // ****************************
  // dac_clk side
  // ****************************
  dacfifo_dac_rd i_dac_rd (
    .dac_clk    (dac_clk),
    .dac_rst    (dac_rst),
    .dac_valid  (dac_valid),
    .xfer_en    (xfer_en),
    .wr_ptr_sync(wr_ptr_sync),
    .mem_rd_data(mem_rd_data),
    .mem_rd_addr(mem_rd_addr),
    .rd_ptr     (rd_ptr),
    .dac_data   (dac_data),
    .dac_dunf   (dac_dunf),
    .level      (level)
  );

  gray_ptr_sync #(.width(dac_addr_width)) i_rd_ptr_sync (
    .src_clk(dac_clk),
    .src_rst(dac_rst),
    .dst_clk(dma_clk),
    .dst_rst(dma_rst),
    .src_ptr(rd_ptr),
    .dst_ptr(rd_ptr_sync)
  );

endmodule

`default_nettype wire

// ==== verif/tb_clkgen.sv ====
// both clocks run at period 10 with dma_clk 3 units late; reset spans two edges of each clock
`default_nettype none

module tb_clkgen (
  output logic dac_clk,
  output logic dma_clk,
  output logic dac_rst
);

  initial begin
    dac_clk = 1'b0;
    forever #5 dac_clk = ~dac_clk;
  end

  initial begin
    dma_clk = 1'b0;
    #3;
    forever #5 dma_clk = ~dma_clk;
  end

  // released on a falling edge, after two rising edges of dac_clk
  initial begin
    dac_rst = 1'b1;
    repeat (2) @(posedge dac_clk);
    @(negedge dac_clk);
    dac_rst = 1'b0;
  end

endmodule

`default_nettype wire

// ==== verif/dacfifo_properties.sv ====
// bound into dacfifo_top; the fill check uses the dma-side copy of the read pointer
`default_nettype none

module dacfifo_properties (
  input logic                                   dac_clk,
  input logic                                   dac_rst,
  input logic                                   dma_clk,
  input logic                                   dma_rst,
  input logic                                   mem_wr_en,
  input logic [dacfifo_pkg::dma_addr_width-1:0] wr_ptr,
  input logic [dacfifo_pkg::dac_addr_width-1:0] rd_ptr_sync,
  input logic                                   xfer_en,
  input logic                                   dac_dunf,
  input dacfifo_pkg::axil_req_t                 csr_req,
  input dacfifo_pkg::axil_rsp_t                 csr_rsp
);

  import dacfifo_pkg::*;

  logic [dma_addr_width-1:0] beats;
  // failed assertions so far
  int                        assert_fails = 0;

  // beats in flight as the write side sees them
  assign beats = wr_ptr - rd_ptr_sync[dac_addr_width-1:1];

  no_write_when_full: assert property (
    @(posedge dma_clk) disable iff (dma_rst !== 1'b0)
    mem_wr_en |-> (beats != '1)
  ) else begin
    $error("memory written while 511 beats are in flight");
    assert_fails++;
  end

  b_valid_holds: assert property (
    @(posedge dac_clk) disable iff (dac_rst)
    (csr_rsp.b_valid && !csr_req.b_ready) |=> csr_rsp.b_valid
  ) else begin
    $error("b_valid dropped before b_ready");
    assert_fails++;
  end

  r_valid_holds: assert property (
    @(posedge dac_clk) disable iff (dac_rst)
    (csr_rsp.r_valid && !csr_req.r_ready) |=> csr_rsp.r_valid
  ) else begin
    $error("r_valid dropped before r_ready");
    assert_fails++;
  end

  // underflow is only meaningful with the transfer enabled
  dunf_needs_enable: assert property (
    @(posedge dac_clk) disable iff (dac_rst)
    $rose(dac_dunf) |-> $past(xfer_en)
  ) else begin
    $error("dac_dunf rose while xfer_en was low");
    assert_fails++;
  end

endmodule

bind dacfifo_top dacfifo_properties props (
  .dac_clk    (dac_clk),
  .dac_rst    (dac_rst),
  .dma_clk    (dma_clk),
  .dma_rst    (dma_rst),
  .mem_wr_en  (mem_wr_en),
  .wr_ptr     (wr_ptr),
  .rd_ptr_sync(rd_ptr_sync),
  .xfer_en    (xfer_en),
  .dac_dunf   (dac_dunf),
  .csr_req    (csr_req),
  .csr_rsp    (csr_rsp)
);

`default_nettype wire

// ==== verif/dacfifo_tb.sv ====
// tests run in order and share fifo state; dma inputs change on falling dma_clk, the rest on dac_clk
`default_nettype none

module dacfifo_tb;

  import dacfifo_pkg::*;

  localparam int budget_reset_id  = 500;
  localparam int budget_width     = 1000;
  localparam int budget_backpress = 5000;
  localparam int budget_underflow = 700;
  localparam int budget_disable   = 800;
  localparam int watchdog_cycles  = budget_reset_id + budget_width + budget_backpress +
                                    budget_underflow + budget_disable;
  localparam int hs_timeout       = 20;

  logic                      dac_clk;
  logic                      dma_clk;
  logic                      dac_rst;
  logic [dma_data_width-1:0] dma_data;
  logic                      dma_valid;
  logic                      dma_ready;
  logic                      dac_valid;
  logic [dac_data_width-1:0] dac_data;
  logic                      dac_dunf;
  axil_req_t                 csr_req;
  axil_rsp_t                 csr_rsp;

  logic [15:0]               lfsr_state;
  logic [dac_data_width-1:0] exp_q[$];
  int                        errors;
  int                        errors_at_start;
  int                        tests_run;
  int                        tests_failed;

  tb_clkgen clkgen (
    .dac_clk(dac_clk),
    .dma_clk(dma_clk),
    .dac_rst(dac_rst)
  );

  dacfifo_top DUT (
    .dac_clk  (dac_clk),
    .dac_rst  (dac_rst),
    .dma_clk  (dma_clk),
    .dma_data (dma_data),
    .dma_valid(dma_valid),
    .dma_ready(dma_ready),
    .dac_valid(dac_valid),
    .dac_data (dac_data),
    .dac_dunf (dac_dunf),
    .csr_req  (csr_req),
    .csr_rsp  (csr_rsp)
  );

  // ******************************
  // helpers
  // ******************************
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    // galois form, x^16 + x^14 + x^13 + x^11 + 1
    if (s[0]) begin
      return (s >> 1) ^ 16'hB400;
    end
    return s >> 1;
  endfunction

  task automatic make_beat(output logic [dma_data_width-1:0] beat);
    for (int i = 0; i < dma_data_width; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      beat[i]    = lfsr_state[0];
    end
  endtask

  task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] want);
    if (got !== want) begin
      $display("ERROR %s: expected %h, got %h", name, want, got);
      errors++;
    end
  endtask

  task automatic start_test();
    errors_at_start = errors;
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (errors > errors_at_start) begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, errors - errors_at_start);
    end else begin
      $display("%s: ok", name);
    end
  endtask

  task automatic axil_write(input logic [axil_addr_width-1:0] addr,
                            input logic [axil_data_width-1:0] data);
    int n;
    @(negedge dac_clk);
    csr_req.aw_addr  = addr;
    csr_req.aw_valid = 1'b1;
    csr_req.w_data   = data;
    csr_req.w_strb   = '1;
    csr_req.w_valid  = 1'b1;
    csr_req.b_ready  = 1'b0;
    n = 0;
    while (!csr_rsp.aw_ready && n < hs_timeout) begin
      @(negedge dac_clk);
      n++;
    end
    if (!csr_rsp.aw_ready) begin
      $display("write to offset %h was never accepted", addr);
      errors++;
    end else begin
      // aw and w are taken together
      check_eq("w_ready", csr_rsp.w_ready, 1);
    end
    // address and data were taken on the rising edge just passed
    @(negedge dac_clk);
    csr_req.aw_valid = 1'b0;
    csr_req.w_valid  = 1'b0;
    n = 0;
    while (!csr_rsp.b_valid && n < hs_timeout) begin
      @(negedge dac_clk);
      n++;
    end
    if (!csr_rsp.b_valid) begin
      $display("no write response for offset %h", addr);
      errors++;
    end else begin
      check_eq("b_resp", csr_rsp.b_resp, resp_okay);
    end
    csr_req.b_ready = 1'b1;
    @(negedge dac_clk);
    csr_req.b_ready = 1'b0;
  endtask

  task automatic axil_read(input logic [axil_addr_width-1:0] addr,
                           output logic [axil_data_width-1:0] data);
    int n;
    @(negedge dac_clk);
    csr_req.ar_addr  = addr;
    csr_req.ar_valid = 1'b1;
    csr_req.r_ready  = 1'b0;
    n = 0;
    while (!csr_rsp.ar_ready && n < hs_timeout) begin
      @(negedge dac_clk);
      n++;
    end
    if (!csr_rsp.ar_ready) begin
      $display("read of offset %h was never accepted", addr);
      errors++;
    end
    @(negedge dac_clk);
    csr_req.ar_valid = 1'b0;
    n = 0;
    while (!csr_rsp.r_valid && n < hs_timeout) begin
      @(negedge dac_clk);
      n++;
    end
    data = csr_rsp.r_data;
    if (!csr_rsp.r_valid) begin
      $display("no read response for offset %h", addr);
      errors++;
    end else begin
      check_eq("r_resp", csr_rsp.r_resp, resp_okay);
    end
    csr_req.r_ready = 1'b1;
    @(negedge dac_clk);
    csr_req.r_ready = 1'b0;
  endtask

  // offers beats back to back until max_beats are taken or ready stays low
  task automatic dma_stream(input int max_beats, input int stall_limit, output int accepted);
    logic [dma_data_width-1:0] beat;
    int                        low_run;
    accepted = 0;
    low_run  = 0;
    @(negedge dma_clk);
    make_beat(beat);
    dma_data  = beat;
    dma_valid = 1'b1;
    while (accepted < max_beats && low_run < stall_limit) begin
      if (dma_ready) begin
        // ready holds through the coming rising edge, so this beat lands
        exp_q.push_back(beat[dac_data_width-1:0]);
        exp_q.push_back(beat[dma_data_width-1:dac_data_width]);
        accepted++;
        low_run = 0;
        @(negedge dma_clk);
        make_beat(beat);
        dma_data = beat;
      end else begin
        low_run++;
        @(negedge dma_clk);
      end
    end
    dma_valid = 1'b0;
  endtask

  task automatic poll_level(input int target, output bit reached);
    logic [axil_data_width-1:0] rd;
    int                         n;
    reached = 1'b0;
    n = 0;
    while (!reached && n < 50) begin
      axil_read(reg_level_addr, rd);
      reached = (rd == target);
      n++;
    end
    if (!reached) begin
      $display("level register never reached %0d samples", target);
      errors++;
    end
  endtask

  // dac_valid every cycle, each sample checked two cycles after its strobe
  task automatic dac_drain(input int count);
    logic [dac_data_width-1:0] want;
    for (int i = 0; i < count + 2; i++) begin
      @(negedge dac_clk);
      dac_valid = (i < count);
      if (i >= 2) begin
        if (exp_q.size() == 0) begin
          $display("more samples read than beats were written");
          errors++;
        end else begin
          want = exp_q.pop_front();
          check_eq("dac_data", dac_data, want);
        end
      end
    end
  endtask

  // ******************************
  // tests
  // ******************************
  task automatic reset_and_id();
    logic [axil_data_width-1:0] rd;
    int                         n;
    start_test();
    check_eq("dac_dunf", dac_dunf, 0);
    check_eq("dac_data", dac_data, 0);
    n = 0;
    while (dma_ready !== 1'b1 && n < 5) begin
      @(negedge dma_clk);
      n++;
    end
    if (dma_ready !== 1'b1) begin
      $display("dma_ready did not rise within 5 dma_clk cycles of reset");
      errors++;
    end
    axil_read(reg_id_addr, rd);
    check_eq("id register", rd, dacfifo_id);
    axil_read(4'h2, rd);
    check_eq("unmapped register", rd, 0);
    report_test("reset and id");
  endtask

  task automatic width_split();
    int accepted;
    bit reached;
    start_test();
    axil_write(reg_ctrl_addr, 32'h1);
    // enable crosses into dma_clk through two flops
    repeat (4) @(negedge dma_clk);
    dma_stream(16, 50, accepted);
    check_eq("accepted beats", accepted, 16);
    poll_level(32, reached);
    dac_drain(32);
    report_test("width split and order");
  endtask

  task automatic back_pressure();
    int accepted;
    bit reached;
    start_test();
    dma_stream(600, 10, accepted);
    if (accepted < dma_thresh_hi || accepted > 511) begin
      $display("ERROR accepted beats: %h outside %h to %h", accepted, dma_thresh_hi, 511);
      errors++;
    end
    poll_level(exp_q.size(), reached);
    dac_drain(exp_q.size());
    report_test("back-pressure");
  endtask

  task automatic underflow();
    logic [axil_data_width-1:0] rd;
    start_test();
    check_eq("dac_dunf", dac_dunf, 0);
    @(negedge dac_clk);
    dac_valid = 1'b1;
    @(negedge dac_clk);
    dac_valid = 1'b0;
    check_eq("dac_dunf", dac_dunf, 1);
    axil_read(reg_status_addr, rd);
    check_eq("status register", rd, 1);
    axil_write(reg_status_addr, 32'h1);
    axil_read(reg_status_addr, rd);
    check_eq("status register", rd, 0);
    report_test("underflow");
  endtask

  task automatic disable_path();
    logic [axil_data_width-1:0] rd;
    logic [dma_data_width-1:0]  beat;
    start_test();
    axil_write(reg_ctrl_addr, 32'h0);
    repeat (4) @(negedge dma_clk);
    for (int i = 0; i < 8; i++) begin
      @(negedge dma_clk);
      make_beat(beat);
      dma_data  = beat;
      dma_valid = 1'b1;
    end
    @(negedge dma_clk);
    dma_valid = 1'b0;
    // long enough for any write pointer change to reach the dac side
    repeat (10) @(negedge dac_clk);
    axil_read(reg_level_addr, rd);
    check_eq("level register", rd, 0);
    for (int i = 0; i < 4; i++) begin
      @(negedge dac_clk);
      dac_valid = 1'b1;
      @(negedge dac_clk);
      dac_valid = 1'b0;
      check_eq("dac_dunf", dac_dunf, 0);
    end
    report_test("disable");
  endtask

  // ******************************
  // main sequence and watchdog
  // ******************************
  initial begin
    dma_data     = '0;
    dma_valid    = 1'b0;
    dac_valid    = 1'b0;
    csr_req      = '0;
    lfsr_state   = 16'd47;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    wait (dac_rst === 1'b0);
    reset_and_id();
    width_split();
    back_pressure();
    underflow();
    disable_path();
    $display("%0d tests, %0d failed, %0d errors, %0d assertion failures",
             tests_run, tests_failed, errors, DUT.props.assert_fails);
    if (errors == 0 && DUT.props.assert_fails == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge dac_clk);
    $display("watchdog expired after %0d dac_clk cycles", watchdog_cycles);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
hw/dacfifo_pkg.sv
hw/gray_ptr_sync.sv
hw/dacfifo_mem_asym.sv
hw/dacfifo_dma_wr.sv
hw/dacfifo_dac_rd.sv
hw/dacfifo_csr.sv
hw/dacfifo_top.sv
verif/tb_clkgen.sv
verif/dacfifo_properties.sv
verif/dacfifo_tb.sv
